/* rtl/csi2_pkg.sv */
package csi2_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream and buffer sizing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int WORD_W       = 32;
  localparam int IN_DEPTH     = 8;   // Also upstream's initial credits.
  localparam int OUT_DEPTH    = 8;
  localparam int SINK_CREDITS = 4;

  localparam logic [5:0] SHORT_DT_MAX = 6'h0F;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Header ECC and payload CRC
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Parity bit k covers the header bits set in ECC_MASK[k].
  localparam logic [5:0][23:0] ECC_MASK = {
    24'hEFFC00,
    24'hDF03F0,
    24'hB8E38E,
    24'h749A6D,
    24'hF2555B,
    24'hF12CB7
  };

  localparam logic [4:0]  ECC_NO_FIX    = 5'h1F;    // Uncorrectable marker.
  localparam logic [15:0] CRC_INIT      = 16'hFFFF;
  localparam logic [15:0] CRC_POLY_REFL = 16'h8408; // 0x1021 bit reversed.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [WORD_W-1:0] csi2_word_t;

  typedef struct packed {
    logic [1:0]  rsvd;
    logic [5:0]  ecc;
    logic [15:0] wc;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } csi2_hdr_t;

  typedef enum logic [1:0] {
    REC_HEADER,
    REC_PAYLOAD,
    REC_STATUS
  } csi2_kind_e;

  typedef struct packed {
    csi2_kind_e kind;
    csi2_word_t data;
    logic       ecc_corrected;
    logic       ecc_error;
    logic       crc_error;
  } csi2_rec_t;

endpackage

/* rtl/csi2_credit_fifo.sv */
`timescale 1ns/1ps

module csi2_credit_fifo #(
  parameter type T            = logic,
  parameter int  DEPTH        = 8,
  parameter int  INIT_CREDITS = 0
)
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic push_valid_i,
  input  T     push_data_i,
  output logic push_credit_o,
  output logic pop_valid_o,
  output T     pop_data_o,
  input  logic pop_credit_i
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int NW = $clog2(DEPTH + 1);
  localparam int CW = $clog2(DEPTH + INIT_CREDITS + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [NW-1:0] count;
  logic [CW-1:0] credits;
  logic          pop;

  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // Sink must take the entry whenever it is shown.
  assign pop         = (count != '0) && (credits != '0);
  assign pop_valid_o = pop;
  assign pop_data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (push_valid_i)
      mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credits       <= CW'(INIT_CREDITS);
      push_credit_o <= 1'b0;
    end
    else
    begin
      if (push_valid_i)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      count         <= count + NW'(push_valid_i) - NW'(pop);
      credits       <= credits + CW'(pop_credit_i) - CW'(pop);
      push_credit_o <= pop;     // Slot freed upstream.
    end
  end

endmodule

/* rtl/csi2_hamming_dec.sv */
`timescale 1ns/1ps

module csi2_hamming_dec
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  csi2_pkg::csi2_word_t data_i,
  input  logic                 pkt_done_i,
  output logic                 error_o,
  output logic                 error_corrected_o,
  output csi2_pkg::csi2_word_t data_o,
  output logic                 valid_o
);

  import csi2_pkg::*;

  logic [5:0] parity;
  logic [5:0] syndrome_d;
  csi2_word_t data_d;
  logic       valid_d;
  logic       header_passed;
  logic       header_valid;
  logic [4:0] err_pos;
  logic       fixable;
  csi2_word_t fix_mask;

  // Maps a syndrome to the bit in error among bits 0 to 29.
  function automatic logic [4:0] err_bit_pos(input logic [5:0] syn);
    logic [4:0] pos;
    case (syn)
      6'h07:   pos = 5'd0;
      6'h0B:   pos = 5'd1;
      6'h0D:   pos = 5'd2;
      6'h0E:   pos = 5'd3;
      6'h13:   pos = 5'd4;
      6'h15:   pos = 5'd5;
      6'h16:   pos = 5'd6;
      6'h19:   pos = 5'd7;
      6'h1A:   pos = 5'd8;
      6'h1C:   pos = 5'd9;
      6'h23:   pos = 5'd10;
      6'h25:   pos = 5'd11;
      6'h26:   pos = 5'd12;
      6'h29:   pos = 5'd13;
      6'h2A:   pos = 5'd14;
      6'h2C:   pos = 5'd15;
      6'h31:   pos = 5'd16;
      6'h32:   pos = 5'd17;
      6'h34:   pos = 5'd18;
      6'h38:   pos = 5'd19;
      6'h1F:   pos = 5'd20;
      6'h2F:   pos = 5'd21;
      6'h37:   pos = 5'd22;
      6'h3B:   pos = 5'd23;
      6'h01:   pos = 5'd24;
      6'h02:   pos = 5'd25;
      6'h04:   pos = 5'd26;
      6'h08:   pos = 5'd27;
      6'h10:   pos = 5'd28;
      6'h20:   pos = 5'd29;
      default: pos = ECC_NO_FIX;  // Zero or multi-bit.
    endcase
    return pos;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 1 forms parity and syndrome
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    for (int k = 0; k < 6; k++)
      parity[k] = ^(data_i[23:0] & ECC_MASK[k]);
  end

  always_ff @(posedge clk_i)
  begin
    data_d     <= data_i;
    syndrome_d <= parity ^ data_i[29:24];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 2 corrects the header word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign header_valid = valid_d && !header_passed;
  assign err_pos      = err_bit_pos(syndrome_d);
  assign fixable      = header_valid && (err_pos != ECC_NO_FIX);
  assign fix_mask     = fixable ? (csi2_word_t'(1) << err_pos) : '0;

  always_ff @(posedge clk_i)
  begin
    data_o <= data_d ^ fix_mask;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_d           <= 1'b0;
      valid_o           <= 1'b0;
      header_passed     <= 1'b0;
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else
    begin
      valid_d <= valid_i;
      valid_o <= valid_d;
      if (header_valid)
      begin
        header_passed     <= 1'b1;
        error_o           <= (syndrome_d != 6'd0);
        error_corrected_o <= fixable;
      end
      else if (pkt_done_i)
      begin
        header_passed     <= 1'b0;  // Next word is a header.
        error_o           <= 1'b0;
        error_corrected_o <= 1'b0;
      end
    end
  end

endmodule

/* rtl/csi2_crc16.sv */
`timescale 1ns/1ps

module csi2_crc16
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 clear_i,
  input  logic                 valid_i,
  input  csi2_pkg::csi2_word_t data_i,
  output logic [15:0]          crc_o
);

  import csi2_pkg::*;

  logic [15:0] crc_q;
  logic [15:0] crc_next;

  // Bits 0 to 31 in order is low byte first, LSB first.
  always_comb
  begin
    crc_next = crc_q;
    for (int i = 0; i < WORD_W; i++)
    begin
      if (crc_next[0] ^ data_i[i])
        crc_next = (crc_next >> 1) ^ CRC_POLY_REFL;
      else
        crc_next = crc_next >> 1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i || clear_i)
      crc_q <= CRC_INIT;
    else if (valid_i)
      crc_q <= crc_next;   // One word per cycle.
  end

  assign crc_o = crc_q;

endmodule

/* rtl/csi2_pkt_ctrl.sv */
`timescale 1ns/1ps

module csi2_pkt_ctrl
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 word_valid_i,
  input  csi2_pkg::csi2_word_t word_data_i,
  output logic                 word_credit_o,
  output logic                 dec_valid_o,
  output csi2_pkg::csi2_word_t dec_data_o,
  output logic                 pkt_done_o,
  input  logic                 dec_valid_i,
  input  csi2_pkg::csi2_word_t dec_data_i,
  input  logic                 ecc_error_i,
  input  logic                 ecc_corrected_i,
  output logic                 crc_clear_o,
  output logic                 crc_valid_o,
  input  logic [15:0]          crc_i,
  output logic                 rec_valid_o,
  output csi2_pkg::csi2_rec_t  rec_o,
  input  logic                 slot_credit_i
);

  import csi2_pkg::*;

  localparam int SW = $clog2(OUT_DEPTH + 1);

  typedef enum logic [1:0] {IDLE, HDR_WAIT, PAYLOAD, CRC} state_e;

  state_e        state;
  csi2_hdr_t     hdr;
  logic [13:0]   n_words;
  logic [13:0]   words_left;
  logic [14:0]   grants_left;
  logic [14:0]   pops_left;
  logic [SW-1:0] free_slots;
  logic          grant;
  logic          hdr_done;
  logic          hdr_long;
  logic          pkt_end;
  logic          dec_last;

  assign hdr         = dec_data_i;
  assign n_words     = hdr.wc[15:2];
  assign hdr_done    = dec_valid_i && (state == HDR_WAIT);
  assign hdr_long    = (hdr.dt > SHORT_DT_MAX) && !(ecc_error_i && !ecc_corrected_i);
  assign pkt_end     = dec_valid_i && (state == CRC);
  assign grant       = (grants_left != '0) && (free_slots != '0);
  assign crc_clear_o = hdr_done;
  assign crc_valid_o = dec_valid_i && (state == PAYLOAD);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input credits, output slot reservation and decoder feed
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      word_credit_o <= 1'b0;
      free_slots    <= SW'(OUT_DEPTH);
      grants_left   <= 15'd1;   // Room for the first header.
      pops_left     <= '0;
      dec_valid_o   <= 1'b0;
      dec_last      <= 1'b0;
      pkt_done_o    <= 1'b0;
    end
    else
    begin
      word_credit_o <= grant;
      free_slots    <= free_slots - SW'(grant) + SW'(slot_credit_i);
      if (hdr_done)
        grants_left <= hdr_long ? {1'b0, n_words} + 15'd1 : 15'd1;
      else if (pkt_end)
        grants_left <= 15'd1;
      else if (grant)
        grants_left <= grants_left - 1'b1;
      if (hdr_done && hdr_long)
        pops_left <= {1'b0, n_words} + 15'd1;
      else if (word_valid_i && (pops_left != '0))
        pops_left <= pops_left - 1'b1;
      dec_valid_o <= word_valid_i;
      dec_last    <= word_valid_i && (pops_left == 15'd1);
      pkt_done_o  <= (dec_valid_o && dec_last) || (hdr_done && !hdr_long);
    end
  end

  always_ff @(posedge clk_i)
  begin
    dec_data_o <= word_data_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet FSM, stepped by decoded words
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state      <= IDLE;
      words_left <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (word_valid_i)
            state <= HDR_WAIT;
        HDR_WAIT:
          if (dec_valid_i)
          begin
            words_left <= n_words;
            if (!hdr_long)
              state <= IDLE;      // Short or uncorrectable.
            else if (n_words == '0)
              state <= CRC;
            else
              state <= PAYLOAD;
          end
        PAYLOAD:
          if (dec_valid_i)
          begin
            words_left <= words_left - 1'b1;
            if (words_left == 14'd1)
              state <= CRC;
          end
        CRC:
          if (dec_valid_i)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      rec_valid_o <= 1'b0;
    else
      rec_valid_o <= dec_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    rec_o.kind          <= REC_PAYLOAD;
    rec_o.data          <= dec_data_i;
    rec_o.ecc_corrected <= 1'b0;
    rec_o.ecc_error     <= 1'b0;
    rec_o.crc_error     <= 1'b0;
    case (state)
      HDR_WAIT:
      begin
        rec_o.kind          <= REC_HEADER;
        rec_o.ecc_corrected <= ecc_corrected_i;
        rec_o.ecc_error     <= ecc_error_i;
      end
      CRC:
      begin
        rec_o.kind      <= REC_STATUS;
        rec_o.data      <= {crc_i, dec_data_i[15:0]};  // Computed over received.
        rec_o.crc_error <= (crc_i != dec_data_i[15:0]);
      end
      default:
        rec_o.kind <= REC_PAYLOAD;
    endcase
  end

endmodule

/* rtl/csi2_rx_top.sv */
`timescale 1ns/1ps

module csi2_rx_top
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  input  csi2_pkg::csi2_word_t in_data_i,
  output logic                 in_credit_o,
  output logic                 out_valid_o,
  output csi2_pkg::csi2_rec_t  out_rec_o,
  input  logic                 out_credit_i
);

  import csi2_pkg::*;

  logic        word_valid;
  csi2_word_t  word_data;
  logic        word_credit;
  logic        dec_in_valid;
  csi2_word_t  dec_in_data;
  logic        pkt_done;
  logic        dec_out_valid;
  csi2_word_t  dec_out_data;
  logic        ecc_error;
  logic        ecc_corrected;
  logic        crc_clear;
  logic        crc_valid;
  logic [15:0] crc;
  logic        rec_valid;
  csi2_rec_t   rec;
  logic        slot_credit;

  csi2_credit_fifo #(
    .T            ( csi2_word_t   ),
    .DEPTH        ( IN_DEPTH      ),
    .INIT_CREDITS ( 0             )
  ) u_in_fifo (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .push_valid_i  ( in_valid_i    ),
    .push_data_i   ( in_data_i     ),
    .push_credit_o ( in_credit_o   ),
    .pop_valid_o   ( word_valid    ),
    .pop_data_o    ( word_data     ),
    .pop_credit_i  ( word_credit   )
  );

  csi2_hamming_dec u_hamming_dec (
    .clk_i             ( clk_i         ),
    .rst_i             ( rst_i         ),
    .valid_i           ( dec_in_valid  ),
    .data_i            ( dec_in_data   ),
    .pkt_done_i        ( pkt_done      ),
    .error_o           ( ecc_error     ),
    .error_corrected_o ( ecc_corrected ),
    .data_o            ( dec_out_data  ),
    .valid_o           ( dec_out_valid )
  );

  csi2_crc16 u_crc16 (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .clear_i ( crc_clear    ),
    .valid_i ( crc_valid    ),
    .data_i  ( dec_out_data ),
    .crc_o   ( crc          )
  );

  csi2_pkt_ctrl u_pkt_ctrl (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .word_valid_i    ( word_valid    ),
    .word_data_i     ( word_data     ),
    .word_credit_o   ( word_credit   ),
    .dec_valid_o     ( dec_in_valid  ),
    .dec_data_o      ( dec_in_data   ),
    .pkt_done_o      ( pkt_done      ),
    .dec_valid_i     ( dec_out_valid ),
    .dec_data_i      ( dec_out_data  ),
    .ecc_error_i     ( ecc_error     ),
    .ecc_corrected_i ( ecc_corrected ),
    .crc_clear_o     ( crc_clear     ),
    .crc_valid_o     ( crc_valid     ),
    .crc_i           ( crc           ),
    .rec_valid_o     ( rec_valid     ),
    .rec_o           ( rec           ),
    .slot_credit_i   ( slot_credit   )
  );

  csi2_credit_fifo #(
    .T            ( csi2_rec_t    ),
    .DEPTH        ( OUT_DEPTH     ),
    .INIT_CREDITS ( SINK_CREDITS  )
  ) u_out_fifo (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .push_valid_i  ( rec_valid     ),
    .push_data_i   ( rec           ),
    .push_credit_o ( slot_credit   ),
    .pop_valid_o   ( out_valid_o   ),
    .pop_data_o    ( out_rec_o     ),
    .pop_credit_i  ( out_credit_i  )
  );

endmodule

/* tests/csi2_rx_model.svh */
`ifndef CSI2_RX_MODEL_SVH
`define CSI2_RX_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet model and expected records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

csi2_word_t send_q[$];   // Words waiting for upstream credits.
csi2_rec_t  exp_q[$];    // Records in arrival order.

// CSI-2 header parity equations over bits 23:0.
function automatic logic [5:0] ecc_encode(input logic [23:0] d);
  logic [5:0] p;
  p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
  p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
  p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
  p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
  p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
  p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
  return p;
endfunction

// Byte-wise CRC-16 taking the low byte first.
function automatic logic [15:0] crc_word(input logic [15:0] crc, input csi2_word_t w);
  logic [15:0] c;
  c = crc;
  for (int b = 0; b < 4; b++)
  begin
    c = c ^ {8'h00, w[8*b +: 8]};
    for (int i = 0; i < 8; i++)
      c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);  // 0x1021 reflected.
  end
  return c;
endfunction

function automatic csi2_rec_t make_rec(input csi2_kind_e kind, input csi2_word_t data,
                                       input logic corr, input logic err, input logic crc_err);
  csi2_rec_t r;
  r.kind          = kind;
  r.data          = data;
  r.ecc_corrected = corr;
  r.ecc_error     = err;
  r.crc_error     = crc_err;
  return r;
endfunction

// Queues one packet; flips of 2 only go into short headers.
task automatic gen_packet(input bit is_long, input int flips, input bit bad_crc);
  logic [23:0] fields;
  csi2_word_t  hdr;
  csi2_word_t  sent;
  csi2_word_t  w;
  logic [15:0] crc_tx;
  logic [15:0] crc_rx;
  int          n;
  int          b0;
  int          b1;
  int          bad_at;
  n = is_long ? int'(rand_below(7)) : 0;
  if (is_long)
    fields = {16'(4 * n), 2'(rand_below(4)), 6'(16 + rand_below(48))};
  else
    fields = {16'(rand_below(65536)), 2'(rand_below(4)), 6'(rand_below(16))};
  hdr  = {2'b00, ecc_encode(fields), fields};
  sent = hdr;
  b0   = int'(rand_below(30));
  b1   = (b0 + 1 + int'(rand_below(29))) % 30;  // Never equal to b0.
  if (flips > 0)
    sent[b0] = ~sent[b0];
  if (flips > 1)
    sent[b1] = ~sent[b1];
  send_q.push_back(sent);
  exp_q.push_back(make_rec(REC_HEADER, (flips > 1) ? sent : hdr, flips == 1, flips > 0, 1'b0));
  if (is_long && flips < 2)
  begin
    crc_tx = 16'hFFFF;
    crc_rx = 16'hFFFF;
    bad_at = bad_crc ? int'(rand_below(n + 1)) : -1;
    for (int i = 0; i < n; i++)
    begin
      w      = {16'(rand_below(65536)), 16'(rand_below(65536))};
      crc_tx = crc_word(crc_tx, w);
      if (bad_at == i)
        w = w ^ (32'd1 << rand_below(32));
      crc_rx = crc_word(crc_rx, w);
      send_q.push_back(w);
      exp_q.push_back(make_rec(REC_PAYLOAD, w, 1'b0, 1'b0, 1'b0));
    end
    w = {16'(rand_below(65536)), crc_tx};
    if (bad_at == n)
      w = w ^ (32'd1 << rand_below(16));  // Hits the CRC field.
    send_q.push_back(w);
    exp_q.push_back(make_rec(REC_STATUS, {crc_rx, w[15:0]}, 1'b0, 1'b0, bad_crc));
  end
endtask

`endif

/* tests/tb_csi2_rx.sv */
`timescale 1ns/1ps

module tb_csi2_rx;

  import csi2_pkg::*;

  localparam int DRAIN_LIMIT = 6000;

  logic        clk;
  logic        rst;
  logic        in_valid;
  csi2_word_t  in_data;
  logic        in_credit;
  logic        out_valid;
  csi2_rec_t   out_rec;
  logic        out_credit;

  logic [31:0] lcg_state;
  int          err_count;
  int          tests_ok;
  int          tests_bad;
  int          up_credits;
  int          words_sent;
  int          in_credit_count;
  int          rec_count;
  int          credits_returned;
  int          pending_credits;
  int          credit_gap;
  bit          stall_mode;
  bit          aborted;

  function automatic int unsigned rand_below(input int unsigned n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'd0, lcg_state[31:16]} % n;
  endfunction

  `include "csi2_rx_model.svh"

  csi2_rx_top csi2_rx_top_inst (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .in_valid_i   ( in_valid   ),
    .in_data_i    ( in_data    ),
    .in_credit_o  ( in_credit  ),
    .out_valid_o  ( out_valid  ),
    .out_rec_o    ( out_rec    ),
    .out_credit_i ( out_credit )
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_record(input csi2_rec_t got);
    csi2_rec_t exp;
    assert (exp_q.size() != 0)
    else
    begin
      err_count++;
      $display("ERROR %0t: record %h arrived with none expected", $time, got);
    end
    if (exp_q.size() != 0)
    begin
      exp = exp_q.pop_front();
      assert (got == exp)
      else
      begin
        err_count++;
        $display("ERROR %0t: got kind %0d %h flags %b%b%b, expected kind %0d %h flags %b%b%b",
                 $time, got.kind, got.data, got.ecc_corrected, got.ecc_error, got.crc_error,
                 exp.kind, exp.data, exp.ecc_corrected, exp.ecc_error, exp.crc_error);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Upstream and downstream credit agents
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk)
  begin
    if (rst)
    begin
      in_valid   <= 1'b0;
      out_credit <= 1'b0;
    end
    else
    begin
      if (in_credit)
      begin
        up_credits++;
        in_credit_count++;
      end
      assert (up_credits <= IN_DEPTH && in_credit_count <= words_sent)
      else
      begin
        err_count++;
        $display("ERROR %0t: %0d input credits back for %0d words, %0d held",
                 $time, in_credit_count, words_sent, up_credits);
      end
      if (out_valid)
      begin
        rec_count++;
        pending_credits++;
        check_record(out_rec);
      end
      assert (rec_count <= SINK_CREDITS + credits_returned)
      else
      begin
        err_count++;
        $display("ERROR %0t: %0d records sent with only %0d credits given",
                 $time, rec_count, SINK_CREDITS + credits_returned);
      end
      if (send_q.size() != 0 && up_credits != 0)
      begin
        in_valid <= 1'b1;
        in_data  <= send_q.pop_front();
        up_credits--;
        words_sent++;
      end
      else
        in_valid <= 1'b0;
      if (pending_credits != 0 && credit_gap == 0)
      begin
        out_credit <= 1'b1;
        pending_credits--;
        credits_returned++;
        if (stall_mode && rand_below(8) == 0)
          credit_gap = 12 + int'(rand_below(24));  // Long stall.
        else
          credit_gap = int'(rand_below(stall_mode ? 4 : 3));
      end
      else
      begin
        out_credit <= 1'b0;
        if (credit_gap != 0)
          credit_gap--;
      end
    end
  end

  function automatic string test_name(input int t);
    case (t)
      1:       return "clean short and long packets";
      2:       return "single-bit header errors";
      3:       return "double-bit header errors";
      4:       return "corrupted payload or CRC";
      default: return "credits under downstream stalls";
    endcase
  endfunction

  task automatic run_test(input int t);
    int errs_before;
    int recs_before;
    bit drained;
    errs_before = err_count;
    recs_before = rec_count;
    drained     = 1'b0;
    @(posedge clk);
    stall_mode = (t == 5);
    for (int p = 0; p < ((t == 5) ? 40 : 24); p++)
    begin
      case (t)
        1: gen_packet(rand_below(2), 0, 1'b0);
        2: gen_packet(rand_below(2), 1, 1'b0);
        3: gen_packet(p % 2, (p % 2) ? 0 : 2, 1'b0);  // Long packets check recovery.
        4: gen_packet(1'b1, 0, 1'b1);
        default:
          if (rand_below(2) != 0)
            gen_packet(1'b1, int'(rand_below(2)), rand_below(4) == 0);
          else
            gen_packet(1'b0, int'(rand_below(3)), 1'b0);
      endcase
    end
    for (int c = 0; c < DRAIN_LIMIT && !drained; c++)
    begin
      @(posedge clk);
      drained = (send_q.size() == 0) && (exp_q.size() == 0) && (pending_credits == 0);
    end
    if (!drained)
    begin
      $display("Timeout: test %0d did not drain within %0d cycles", t, DRAIN_LIMIT);
      aborted = 1'b1;
      tests_bad++;
    end
    else
    begin
      assert (in_credit_count == words_sent && rec_count == words_sent)
      else
      begin
        err_count++;
        $display("ERROR %0t: %0d words sent, %0d input credits, %0d records",
                 $time, words_sent, in_credit_count, rec_count);
      end
      if (err_count == errs_before)
        tests_ok++;
      else
        tests_bad++;
      $display("test %0d %s: %s, %0d records, %0d errors", t, test_name(t),
               (err_count == errs_before) ? "ok" : "bad", rec_count - recs_before,
               err_count - errs_before);
    end
  endtask

  initial
  begin
    lcg_state        = 32'd63586;
    err_count        = 0;
    tests_ok         = 0;
    tests_bad        = 0;
    up_credits       = IN_DEPTH;
    words_sent       = 0;
    in_credit_count  = 0;
    rec_count        = 0;
    credits_returned = 0;
    pending_credits  = 0;
    credit_gap       = 0;
    stall_mode       = 1'b0;
    aborted          = 1'b0;
    rst              = 1'b1;
    in_valid         = 1'b0;
    in_data          = '0;
    out_credit       = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
    for (int t = 1; t <= 5 && !aborted; t++)
      run_test(t);
    $display("Summary: %0d tests ok, %0d tests bad, %0d errors, %0d words, %0d records",
             tests_ok, tests_bad, err_count, words_sent, rec_count);
    if (!aborted && err_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+tests
rtl/csi2_pkg.sv
rtl/csi2_credit_fifo.sv
rtl/csi2_hamming_dec.sv
rtl/csi2_crc16.sv
rtl/csi2_pkt_ctrl.sv
rtl/csi2_rx_top.sv
tests/tb_csi2_rx.sv
